// ==== rtl/vfu_cfg_pkg.sv ====
/*
 * vfu configuration
 * register, lane and element sizes of the vector function unit,
 * together with the vector typedefs that every block shares
 */
`default_nettype none

package vfu_cfg_pkg;

    localparam int VLEN_BITS  = 256;
    localparam int LANE_COUNT = 2;
    localparam int ELEM_BITS  = 32;
    localparam int MAX_ELEMS  = VLEN_BITS / 8;

    // count must reach MAX_ELEMS itself
    localparam int VLEN_W = $clog2(MAX_ELEMS) + 1;

    typedef logic [VLEN_BITS-1:0] vreg_t;

    // narrower elements are zero-extended
    typedef logic [ELEM_BITS-1:0] elem_t;

    typedef logic [VLEN_W-1:0]    vlen_t;
    typedef logic [MAX_ELEMS-1:0] mask_t;

endpackage

`default_nettype wire

// ==== rtl/vfu_op_pkg.sv ====
/*
 * vfu operation encodings
 * decoded opcode, element width, operand form and the
 * sequencer states of the vector function unit
 */
`default_nettype none

package vfu_op_pkg;

    typedef enum logic [1:0] {
        VOP_ADD  = 2'd0,
        VOP_SUB  = 2'd1,
        VOP_MACC = 2'd2,
        VOP_XOR  = 2'd3
    } vop_e;

    // value doubles as the shift from 8 bit elements
    typedef enum logic [1:0] {
        SEW_E8  = 2'd0,
        SEW_E16 = 2'd1,
        SEW_E32 = 2'd2
    } sew_e;

    typedef enum logic {
        OPND_VV = 1'b0,
        OPND_VX = 1'b1
    } operand_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } seq_state_e;

endpackage

`default_nettype wire

// ==== rtl/vfu_lane.sv ====
/*
 * vfu lane
 * arithmetic of one element: add, reverse sub, multiply-accumulate
 * and xor, cut to the element width and zero-extended
 */
`timescale 1ns/1ps
`default_nettype none

module vfu_lane
    import vfu_cfg_pkg::*, vfu_op_pkg::*;
(
    input  sew_e  sew_i,
    input  vop_e  op_i,
    input  elem_t a_i,
    input  elem_t b_i,
    input  elem_t c_i,
    output elem_t res_o
);

    elem_t full;

    // low bits only depend on low bits of the operands
    always_comb begin
        case (op_i)
            VOP_ADD:  full = b_i + a_i;
            VOP_SUB:  full = b_i - a_i;
            VOP_MACC: full = a_i * b_i + c_i;
            VOP_XOR:  full = a_i ^ b_i;
            default:  full = '0;
        endcase
    end

    always_comb begin
        res_o = '0;
        case (sew_i)
            SEW_E8:  res_o[7:0]  = full[7:0];
            SEW_E16: res_o[15:0] = full[15:0];
            SEW_E32: res_o       = full;
            default: res_o       = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/vfu_lane_feed.sv ====
/*
 * vfu lane feed
 * slices the operands of each lane out of the vector registers at
 * the current element index and width, and flags which lanes hold
 * a body element that the mask lets through
 */
`timescale 1ns/1ps
`default_nettype none

module vfu_lane_feed
    import vfu_cfg_pkg::*, vfu_op_pkg::*;
(
    input  sew_e                  sew_i,
    input  operand_e              operand_i,
    input  logic                  vm_i,
    input  vlen_t                 length_i,
    input  vlen_t                 elem_idx_i,
    input  vreg_t                 vs1_i,
    input  vreg_t                 vs2_i,
    input  vreg_t                 vs3_i,
    input  mask_t                 mask_i,
    input  elem_t                 rs_i,
    output elem_t                 a_o [LANE_COUNT],
    output elem_t                 b_o [LANE_COUNT],
    output elem_t                 c_o [LANE_COUNT],
    output logic [LANE_COUNT-1:0] active_o
);

    // element idx of v at width sew, zero-extended
    function automatic elem_t pick(input vreg_t v, input sew_e sew, input vlen_t idx);
        elem_t e;
        e = '0;
        case (sew)
            SEW_E8:  e[7:0]  = v[idx[4:0]*8 +: 8];
            SEW_E16: e[15:0] = v[idx[3:0]*16 +: 16];
            SEW_E32: e       = v[idx[2:0]*32 +: 32];
            default: e       = '0;
        endcase
        return e;
    endfunction

    elem_t rs_elem;

    // scalar cut to the element width, as element 0
    assign rs_elem = pick(vreg_t'(rs_i), sew_i, '0);

    for (genvar l = 0; l < LANE_COUNT; l++) begin : g_lane
        vlen_t idx;

        assign idx         = vlen_t'(elem_idx_i + l);
        assign a_o[l]      = (operand_i == OPND_VX) ? rs_elem : pick(vs1_i, sew_i, idx);
        assign b_o[l]      = pick(vs2_i, sew_i, idx);
        assign c_o[l]      = pick(vs3_i, sew_i, idx);
        assign active_o[l] = (idx < length_i) && (vm_i || mask_i[idx[4:0]]);
    end

endmodule

`default_nettype wire

// ==== rtl/vfu_collector.sv ====
/*
 * vfu collector
 * result register of the unit; preloaded from vs3 when an
 * instruction is accepted, then overwritten element by element by
 * the active lanes, so masked and tail elements stay undisturbed
 */
`timescale 1ns/1ps
`default_nettype none

module vfu_collector
    import vfu_cfg_pkg::*, vfu_op_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  load_i,
    input  logic                  run_i,
    input  sew_e                  sew_i,
    input  vlen_t                 elem_idx_i,
    input  vreg_t                 vs3_i,
    input  logic [LANE_COUNT-1:0] active_i,
    input  elem_t                 res_i [LANE_COUNT],
    output vreg_t                 old_o,
    output vreg_t                 result_o
);

    vreg_t result_q;
    vreg_t result_d;
    vlen_t slot;

    always_comb begin
        result_d = result_q;
        slot     = '0;
        for (int l = 0; l < LANE_COUNT; l++) begin
            slot = vlen_t'(int'(elem_idx_i) + l);
            if (active_i[l]) begin
                case (sew_i)
                    SEW_E8:  result_d[slot[4:0]*8 +: 8]   = res_i[l][7:0];
                    SEW_E16: result_d[slot[3:0]*16 +: 16] = res_i[l][15:0];
                    SEW_E32: result_d[slot[2:0]*32 +: 32] = res_i[l];
                    default: result_d = result_q;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            result_q <= '0;
        end else if (load_i) begin
            result_q <= vs3_i;
        end else if (run_i) begin
            result_q <= result_d;
        end
    end

    // current contents also serve as the macc addend
    assign old_o    = result_q;
    assign result_o = result_q;

endmodule

`default_nettype wire

// ==== rtl/vfu_sequencer.sv ====
/*
 * vfu sequencer
 * accepts one instruction on a start pulse, keeps a copy of its
 * operands and steps the element index LANE_COUNT at a time until
 * the clamped length is covered, then signals done
 */
`timescale 1ns/1ps
`default_nettype none

module vfu_sequencer
    import vfu_cfg_pkg::*, vfu_op_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     start_i,
    input  vop_e     op_i,
    input  sew_e     sew_i,
    input  operand_e operand_i,
    input  logic     vm_i,
    input  vlen_t    length_i,
    input  vreg_t    vs1_i,
    input  vreg_t    vs2_i,
    input  mask_t    mask_i,
    input  elem_t    rs_i,
    output vop_e     op_o,
    output sew_e     sew_o,
    output operand_e operand_o,
    output logic     vm_o,
    output vlen_t    length_o,
    output vreg_t    vs1_o,
    output vreg_t    vs2_o,
    output mask_t    mask_o,
    output elem_t    rs_o,
    output vlen_t    elem_idx_o,
    output logic     load_o,
    output logic     run_o,
    output logic     busy_o,
    output logic     done_o
);

    seq_state_e state_q;
    seq_state_e state_d;
    vlen_t      elem_idx_q;
    vlen_t      length_q;
    vlen_t      len_limit;
    vlen_t      len_clamped;
    logic       done_q;
    logic       accept;
    logic       last_group;

    // done_q still counts as busy
    assign accept = start_i && (state_q == ST_IDLE) && !done_q;

    // 32, 16 or 8 elements fit in one register
    assign len_limit   = vlen_t'(MAX_ELEMS >> sew_i);
    assign len_clamped = (length_i > len_limit) ? len_limit : length_i;
    assign last_group  = (int'(elem_idx_q) + LANE_COUNT) >= int'(length_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = (len_clamped == '0) ? ST_DONE : ST_RUN;
                end
            end
            ST_RUN: begin
                if (last_group) begin
                    state_d = ST_DONE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= ST_IDLE;
            elem_idx_q <= '0;
            length_q   <= '0;
            done_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= (state_q == ST_DONE);
            if (accept) begin
                elem_idx_q <= '0;
                length_q   <= len_clamped;
            end else if (state_q == ST_RUN) begin
                elem_idx_q <= vlen_t'(int'(elem_idx_q) + LANE_COUNT);
            end
        end
    end

    // operand copy of the accepted instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            op_o      <= op_i;
            sew_o     <= sew_i;
            operand_o <= operand_i;
            vm_o      <= vm_i;
            vs1_o     <= vs1_i;
            vs2_o     <= vs2_i;
            mask_o    <= mask_i;
            rs_o      <= rs_i;
        end
    end

    assign length_o   = length_q;
    assign elem_idx_o = elem_idx_q;
    assign load_o     = accept;
    assign run_o      = (state_q == ST_RUN);
    assign busy_o     = (state_q != ST_IDLE) || done_q;
    assign done_o     = done_q;

endmodule

`default_nettype wire

// ==== rtl/vfu_top.sv ====
/*
 * vector function unit
 * sequencer, lane feed, LANE_COUNT parallel lanes and the result
 * collector; one instruction per start pulse, busy and done strobes
 */
`timescale 1ns/1ps
`default_nettype none

module vfu_top
    import vfu_cfg_pkg::*, vfu_op_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     start_i,
    input  vop_e     op_i,
    input  sew_e     sew_i,
    input  operand_e operand_i,
    input  logic     vm_i,
    input  vlen_t    length_i,
    input  vreg_t    vs1_i,
    input  vreg_t    vs2_i,
    input  vreg_t    vs3_i,
    input  mask_t    mask_i,
    input  elem_t    rs_i,
    output logic     busy_o,
    output logic     done_o,
    output vreg_t    result_o
);

    vop_e     seq_op;
    sew_e     seq_sew;
    operand_e seq_operand;
    logic     seq_vm;
    vlen_t    seq_length;
    vreg_t    seq_vs1;
    vreg_t    seq_vs2;
    mask_t    seq_mask;
    elem_t    seq_rs;
    vlen_t    elem_idx;
    logic     load;
    logic     run;
    vreg_t    old_vec;

    elem_t                 lane_a   [LANE_COUNT];
    elem_t                 lane_b   [LANE_COUNT];
    elem_t                 lane_c   [LANE_COUNT];
    elem_t                 lane_res [LANE_COUNT];
    logic [LANE_COUNT-1:0] lane_active;

    vfu_sequencer u_sequencer (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .start_i    (start_i),
        .op_i       (op_i),
        .sew_i      (sew_i),
        .operand_i  (operand_i),
        .vm_i       (vm_i),
        .length_i   (length_i),
        .vs1_i      (vs1_i),
        .vs2_i      (vs2_i),
        .mask_i     (mask_i),
        .rs_i       (rs_i),
        .op_o       (seq_op),
        .sew_o      (seq_sew),
        .operand_o  (seq_operand),
        .vm_o       (seq_vm),
        .length_o   (seq_length),
        .vs1_o      (seq_vs1),
        .vs2_o      (seq_vs2),
        .mask_o     (seq_mask),
        .rs_o       (seq_rs),
        .elem_idx_o (elem_idx),
        .load_o     (load),
        .run_o      (run),
        .busy_o     (busy_o),
        .done_o     (done_o)
    );

    vfu_lane_feed u_feed (
        .sew_i      (seq_sew),
        .operand_i  (seq_operand),
        .vm_i       (seq_vm),
        .length_i   (seq_length),
        .elem_idx_i (elem_idx),
        .vs1_i      (seq_vs1),
        .vs2_i      (seq_vs2),
        .vs3_i      (old_vec),
        .mask_i     (seq_mask),
        .rs_i       (seq_rs),
        .a_o        (lane_a),
        .b_o        (lane_b),
        .c_o        (lane_c),
        .active_o   (lane_active)
    );

    for (genvar l = 0; l < LANE_COUNT; l++) begin : g_lane
        vfu_lane u_lane (
            .sew_i (seq_sew),
            .op_i  (seq_op),
            .a_i   (lane_a[l]),
            .b_i   (lane_b[l]),
            .c_i   (lane_c[l]),
            .res_o (lane_res[l])
        );
    end

    vfu_collector u_collector (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .load_i     (load),
        .run_i      (run),
        .sew_i      (seq_sew),
        .elem_idx_i (elem_idx),
        .vs3_i      (vs3_i),
        .active_i   (lane_active),
        .res_i      (lane_res),
        .old_o      (old_vec),
        .result_o   (result_o)
    );

endmodule

`default_nettype wire

// ==== sim/tb_vfu_model.svh ====
/*
 * vfu reference model
 * expected result vector of one instruction, worked out element by
 * element from the operation rules, and the LCG for the stimulus
 */
`ifndef TB_VFU_MODEL_SVH
`define TB_VFU_MODEL_SVH

// classic ANSI C constants
function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

function automatic int elem_width(input sew_e sew);
    case (sew)
        SEW_E8:  return 8;
        SEW_E16: return 16;
        default: return 32;
    endcase
endfunction

// length limited to the elements that fit in one register
function automatic int clamp_length(input vlen_t length, input sew_e sew);
    int count;
    count = VLEN_BITS / elem_width(sew);
    return (int'(length) > count) ? count : int'(length);
endfunction

function automatic vreg_t model_result(
    input vop_e     op,
    input sew_e     sew,
    input operand_e opnd,
    input logic     vm,
    input vlen_t    length,
    input vreg_t    vs1,
    input vreg_t    vs2,
    input vreg_t    vs3,
    input mask_t    mask,
    input elem_t    rs
);
    int          ebits;
    logic [63:0] emask;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] r;
    vreg_t       res;
    ebits = elem_width(sew);
    emask = (64'd1 << ebits) - 64'd1;
    // masked-off and tail elements stay as in vs3
    res   = vs3;
    for (int i = 0; i < clamp_length(length, sew); i++) begin
        if (vm || mask[i]) begin
            a = (opnd == OPND_VX) ? rs : 32'(vs1 >> (i * ebits));
            a = a & emask[31:0];
            b = 32'(vs2 >> (i * ebits)) & emask[31:0];
            c = 32'(vs3 >> (i * ebits)) & emask[31:0];
            case (op)
                VOP_ADD:  r = b + a;
                VOP_SUB:  r = b - a;
                VOP_MACC: r = a * b + c;
                default:  r = a ^ b;
            endcase
            r   = r & emask[31:0];
            res = (res & ~(vreg_t'(emask[31:0]) << (i * ebits))) | (vreg_t'(r) << (i * ebits));
        end
    end
    return res;
endfunction

`endif

// ==== sim/tb_vfu.sv ====
/*
 * vfu testbench
 * random instructions from a fixed seed against the reference
 * model, with done latency, busy level and ignored start checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_vfu
    import vfu_cfg_pkg::*, vfu_op_pkg::*;
;

    localparam int NUM_INSTR   = 54;
    localparam int CYCLE_LIMIT = 2 * NUM_INSTR * 18;

    logic     clk = 1'b0;
    logic     arst_n_i;
    logic     start_i;
    vop_e     op_i;
    sew_e     sew_i;
    operand_e operand_i;
    logic     vm_i;
    vlen_t    length_i;
    vreg_t    vs1_i;
    vreg_t    vs2_i;
    vreg_t    vs3_i;
    mask_t    mask_i;
    elem_t    rs_i;
    logic     busy_o;
    logic     done_o;
    vreg_t    result_o;

    logic [31:0] lcg_state = 32'hc7c8;
    int          cycle_count = 0;

    `include "tb_vfu_model.svh"

    vfu_top UUT (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .start_i   (start_i),
        .op_i      (op_i),
        .sew_i     (sew_i),
        .operand_i (operand_i),
        .vm_i      (vm_i),
        .length_i  (length_i),
        .vs1_i     (vs1_i),
        .vs2_i     (vs2_i),
        .vs3_i     (vs3_i),
        .mask_i    (mask_i),
        .rs_i      (rs_i),
        .busy_o    (busy_o),
        .done_o    (done_o),
        .result_o  (result_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            stop_with_failure("timeout: the run went past its cycle limit");
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_vreg(input string name, input vreg_t got, input vreg_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("mismatch %s: got %h, expected %h", name, got, expected));
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("mismatch %s: got %h, expected %h", name, got, expected));
        end
    endtask

    // upper halves of two steps, the low LCG bits are weak
    function automatic logic [31:0] rand32();
        logic [31:0] hi;
        lcg_state = lcg_step(lcg_state);
        hi        = lcg_state;
        lcg_state = lcg_step(lcg_state);
        return {hi[31:16], lcg_state[31:16]};
    endfunction

    function automatic vreg_t rand_vreg();
        vreg_t v;
        for (int w = 0; w < VLEN_BITS / 32; w++) begin
            v[w*32 +: 32] = rand32();
        end
        return v;
    endfunction

    function automatic vop_e op_from(input int n);
        case (n)
            0:       return VOP_ADD;
            1:       return VOP_SUB;
            2:       return VOP_MACC;
            default: return VOP_XOR;
        endcase
    endfunction

    function automatic sew_e sew_from(input int n);
        case (n)
            0:       return SEW_E8;
            1:       return SEW_E16;
            default: return SEW_E32;
        endcase
    endfunction

    // new operands on every input, all of them must be ignored
    task automatic scramble_inputs(input logic start);
        start_i   = start;
        op_i      = op_from(int'(rand32() % 32'd4));
        sew_i     = sew_from(int'(rand32() % 32'd3));
        operand_i = ((rand32() % 32'd2) == 32'd0) ? OPND_VV : OPND_VX;
        length_i  = vlen_t'(rand32() % 32'd40);
        vm_i      = rand32() > 32'h8000_0000;
        vs1_i     = rand_vreg();
        vs2_i     = rand_vreg();
        vs3_i     = rand_vreg();
        mask_i    = rand32();
        rs_i      = rand32();
    endtask

    task automatic run_instr(
        input vop_e     op,
        input sew_e     sew,
        input operand_e opnd,
        input logic     vm,
        input vlen_t    length,
        input logic     inject_starts
    );
        vreg_t vs1;
        vreg_t vs2;
        vreg_t vs3;
        mask_t mask;
        elem_t rs;
        vreg_t expected;
        int    expected_edges;
        int    edges;
        vs1            = rand_vreg();
        vs2            = rand_vreg();
        vs3            = rand_vreg();
        mask           = rand32();
        rs             = rand32();
        expected       = model_result(op, sew, opnd, vm, length, vs1, vs2, vs3, mask, rs);
        expected_edges = (clamp_length(length, sew) + LANE_COUNT - 1) / LANE_COUNT + 1;
        start_i   = 1'b1;
        op_i      = op;
        sew_i     = sew;
        operand_i = opnd;
        vm_i      = vm;
        length_i  = length;
        vs1_i     = vs1;
        vs2_i     = vs2;
        vs3_i     = vs3;
        mask_i    = mask;
        rs_i      = rs;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        edges   = 0;
        while (edges < expected_edges) begin
            compare_flag("busy_o", busy_o, 1'b1);
            compare_flag("done_o", done_o, 1'b0);
            if (inject_starts) begin
                scramble_inputs((edges % 2) == 0);
            end
            @(posedge clk);
            #1;
            edges++;
        end
        compare_flag("done_o", done_o, 1'b1);
        compare_flag("busy_o", busy_o, 1'b1);
        compare_vreg("result_o", result_o, expected);
        // the done cycle still counts as busy
        if (inject_starts) begin
            scramble_inputs(1'b1);
        end else begin
            start_i = 1'b0;
        end
        @(posedge clk);
        #1;
        start_i = 1'b0;
        compare_flag("done_o", done_o, 1'b0);
        compare_flag("busy_o", busy_o, 1'b0);
        compare_vreg("result_o", result_o, expected);
    endtask

    initial begin
        logic [31:0] r;
        arst_n_i  = 1'b0;
        start_i   = 1'b0;
        op_i      = VOP_ADD;
        sew_i     = SEW_E8;
        operand_i = OPND_VV;
        vm_i      = 1'b1;
        length_i  = '0;
        vs1_i     = '0;
        vs2_i     = '0;
        vs3_i     = '0;
        mask_i    = '0;
        rs_i      = '0;
        repeat (5) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        compare_flag("busy_o", busy_o, 1'b0);
        compare_flag("done_o", done_o, 1'b0);
        compare_vreg("result_o", result_o, '0);

        // full length, unmasked, both operand forms
        for (int f = 0; f < 2; f++) begin
            for (int o = 0; o < 4; o++) begin
                for (int s = 0; s < 3; s++) begin
                    run_instr(op_from(o), sew_from(s), (f == 0) ? OPND_VV : OPND_VX, 1'b1,
                              vlen_t'(MAX_ELEMS), 1'b0);
                end
            end
        end

        // masked, with short, empty and oversized lengths
        for (int i = 0; i < 24; i++) begin
            r = rand32();
            run_instr(op_from(int'(r[1:0])), sew_from(int'(r[5:4] % 2'd3)),
                      r[8] ? OPND_VX : OPND_VV, 1'b0,
                      (i == 0) ? vlen_t'(0) : (i == 1) ? vlen_t'(45) : vlen_t'(rand32() % 32'd40),
                      1'b0);
        end

        // start pulses while busy
        for (int i = 0; i < 6; i++) begin
            r = rand32();
            run_instr(op_from(int'(r[1:0])), sew_from(int'(r[5:4] % 2'd3)),
                      r[8] ? OPND_VX : OPND_VV, r[12],
                      (i == 0) ? vlen_t'(0) : vlen_t'(rand32() % 32'd40), 1'b1);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+sim
rtl/vfu_cfg_pkg.sv
rtl/vfu_op_pkg.sv
rtl/vfu_lane.sv
rtl/vfu_lane_feed.sv
rtl/vfu_collector.sv
rtl/vfu_sequencer.sv
rtl/vfu_top.sv
sim/tb_vfu.sv

// ==== Makefile ====
# Verilator build and run of the vfu testbench

VERILATOR ?= verilator
TOP       ?= tb_vfu
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard rtl/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) files.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f files.f

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
